//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // widths
    localparam int unsigned xlen       = 64;
    localparam int unsigned vpn_w      = 9;  // one vpn field
    localparam int unsigned ppn_w      = 44;
    localparam int unsigned page_bits  = 12; // 4 KiB page offset
    localparam int unsigned max_levels = 5;  // sv57 depth

    // satp mode field, bits 63:60
    localparam logic [3:0] satp_sv39 = 4'd8;
    localparam logic [3:0] satp_sv48 = 4'd9;
    localparam logic [3:0] satp_sv57 = 4'd10;

    // page table entry bit positions
    localparam int unsigned pte_v   = 0;
    localparam int unsigned pte_r   = 1;
    localparam int unsigned pte_w   = 2;
    localparam int unsigned pte_x   = 3;
    localparam int unsigned ppn_lsb = 10; // ppn starts here in the entry

    typedef logic [2:0] level_t; // walk level, 0 is the last

    typedef struct packed {
        logic [xlen-1:0] vaddr;
        logic [xlen-1:0] satp;
    } xlat_req_t;

    typedef struct packed {
        logic [xlen-1:0] padd; // page aligned
        logic [7:0]      perm; // zero on fault
    } xlat_rsp_t;

    typedef struct packed {
        logic [7:0]      arid;
        logic [xlen-1:0] araddr;
        logic [7:0]      arlen;
        logic [2:0]      arsize;
        logic [1:0]      arburst;
        logic            arlock;
        logic [3:0]      arcache;
        logic [2:0]      arprot;
        logic [3:0]      arqos;
        logic            arvalid;
    } axi_ar_t;

    typedef struct packed {
        logic [7:0]      rid;
        logic [xlen-1:0] rdata;
        logic            rlast;
        logic            rvalid;
    } axi_r_t;

    typedef enum logic [1:0] {
        pte_fault,
        pte_leaf,
        pte_next
    } pte_kind_t;

endpackage

`default_nettype wire

//--- pte_check.sv
`default_nettype none

module pte_check (
    input  logic [mmu_pkg::xlen-1:0]  pte,
    input  mmu_pkg::level_t           level,
    input  logic [mmu_pkg::xlen-1:0]  vpn_in, // full virtual address
    output mmu_pkg::pte_kind_t        kind,
    output logic [mmu_pkg::ppn_w-1:0] leaf_ppn
);
    import mmu_pkg::*;

    logic is_valid;
    logic is_leaf;
    logic misaligned;

    always_comb is_valid = pte[pte_v];
    always_comb is_leaf  = pte[pte_r] | pte[pte_x]; // w alone is a pointer here

    // superpage: low ppn fields come from the virtual address
    always_comb begin
        leaf_ppn   = pte[ppn_lsb +: ppn_w];
        misaligned = 1'b0;
        for (int i = 0; i < max_levels - 1; i++) begin
            if (i < int'(level)) begin
                if (pte[ppn_lsb + i*vpn_w +: vpn_w] != '0)
                    misaligned = 1'b1; // low field must be clear
                leaf_ppn[i*vpn_w +: vpn_w] = vpn_in[page_bits + i*vpn_w +: vpn_w];
            end
        end
    end

    always_comb begin
        if (!is_valid)
            kind = pte_fault;
        else if (is_leaf)
            kind = misaligned ? pte_fault : pte_leaf;
        else if (level == '0)
            kind = pte_fault; // pointer with nowhere left to go
        else
            kind = pte_next;
    end

    level_in_range: assert final ($isunknown(level) || level < max_levels)
        else $error("pte_check: level %0d out of range", level);

endmodule

`default_nettype wire

//--- ptw_walker.sv
`default_nettype none

module ptw_walker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  mmu_pkg::xlat_req_t       xreq,
    output logic                     ack,
    output mmu_pkg::xlat_rsp_t       rsp,
    output logic                     rd_req,
    output logic [mmu_pkg::xlen-1:0] rd_addr,
    input  logic                     rd_ack,
    input  logic [mmu_pkg::xlen-1:0] rd_data
);
    import mmu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_read,
        st_check,
        st_done
    } state_t;

    state_t           state;
    level_t           lvl;      // current level
    logic [xlen-1:0]  vaddr;    // latched virtual address
    logic [ppn_w-1:0] ppn;      // table base of current level
    logic [xlen-1:0]  pte_q;    // fetched entry
    logic [vpn_w-1:0] vpn_sel;
    logic [3:0]       mode;
    pte_kind_t        kind;
    logic [ppn_w-1:0] leaf_ppn;

    always_comb mode    = xreq.satp[xlen-1 -: 4];
    always_comb vpn_sel = vaddr[page_bits + int'(lvl)*vpn_w +: vpn_w];

    pte_check u_check (
        .pte      (pte_q),
        .level    (lvl),
        .vpn_in   (vaddr),
        .kind     (kind),
        .leaf_ppn (leaf_ppn)
    );

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            lvl    <= '0;
            ack    <= 1'b0;
            rd_req <= 1'b0;
        end else begin
            case (state)
                st_idle:
                    if (req) begin
                        case (mode)
                            satp_sv39: begin lvl <= 3'd2; state <= st_addr; end
                            satp_sv48: begin lvl <= 3'd3; state <= st_addr; end
                            satp_sv57: begin lvl <= 3'd4; state <= st_addr; end
                            default:   state <= st_done; // bad mode, no reads
                        endcase
                    end
                st_addr: begin
                    rd_req <= 1'b1;
                    state  <= st_read;
                end
                st_read:
                    if (rd_req) begin
                        if (rd_ack)
                            rd_req <= 1'b0;
                    end else if (!rd_ack) begin
                        state <= st_check; // port back to idle
                    end
                st_check:
                    if (kind == pte_next) begin
                        lvl   <= lvl - 3'd1;
                        state <= st_addr;
                    end else begin
                        state <= st_done;
                    end
                st_done:
                    if (ack && !req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end else begin
                        ack <= 1'b1;
                    end
                default: state <= st_idle;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        case (state)
            st_idle:
                if (req) begin
                    vaddr    <= xreq.vaddr;
                    ppn      <= xreq.satp[ppn_w-1:0];
                    rsp.padd <= '0;
                    rsp.perm <= '0; // stays zero unless a leaf is found
                end
            st_addr:
                rd_addr <= {{(xlen-ppn_w-vpn_w-3){1'b0}}, ppn, vpn_sel, 3'b000};
            st_read:
                if (rd_req && rd_ack)
                    pte_q <= rd_data;
            st_check:
                if (kind == pte_leaf) begin
                    rsp.padd <= {{(xlen-ppn_w-page_bits){1'b0}}, leaf_ppn, {page_bits{1'b0}}};
                    rsp.perm <= pte_q[7:0];
                end else if (kind == pte_next) begin
                    ppn <= pte_q[ppn_lsb +: ppn_w];
                end
            default: ;
        endcase
    end

    // requester must see ack drop right after it releases req
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        (ack && !req) |=> !ack)
        else $error("ptw_walker: ack held after req fell");

    rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rd_req |=> (!rd_req || $stable(rd_addr)))
        else $error("ptw_walker: rd_addr changed during read");

endmodule

`default_nettype wire

//--- axi_rd_port.sv
`default_nettype none

module axi_rd_port #(
    parameter logic [7:0] axi_id = 8'h00
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_req,
    input  logic [mmu_pkg::xlen-1:0] rd_addr,
    output logic                     rd_ack,
    output logic [mmu_pkg::xlen-1:0] rd_data,
    output mmu_pkg::axi_ar_t         ar,
    input  logic                     arready,
    input  mmu_pkg::axi_r_t          r,
    output logic                     rready
);
    import mmu_pkg::*;

    logic            ar_valid;
    logic [xlen-1:0] ar_addr;
    logic            start;
    logic            beat;

    always_comb start = rd_req & ~ar_valid & ~rready & ~rd_ack;
    always_comb beat  = rready & r.rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
            rready   <= 1'b0;
            rd_ack   <= 1'b0;
        end else begin
            if (start)
                ar_valid <= 1'b1;
            if (ar_valid && arready) begin
                ar_valid <= 1'b0;
                rready   <= 1'b1; // wait for the single beat
            end
            if (beat) begin
                rready <= 1'b0;
                rd_ack <= 1'b1;
            end
            if (rd_ack && !rd_req)
                rd_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            ar_addr <= rd_addr;
        if (beat)
            rd_data <= r.rdata; // response code not used
    end

    always_comb begin
        ar.arid    = axi_id;
        ar.araddr  = ar_addr;
        ar.arlen   = 8'd0;     // one beat
        ar.arsize  = 3'b011;   // 8 bytes
        ar.arburst = 2'b01;    // incr
        ar.arlock  = 1'b0;
        ar.arcache = 4'd0;
        ar.arprot  = 3'd0;
        ar.arqos   = 4'd0;
        ar.arvalid = ar_valid;
    end

    araddr_held: assert property (@(posedge clk) disable iff (rst)
        (ar.arvalid && !arready) |=> (ar.arvalid && $stable(ar.araddr)))
        else $error("axi_rd_port: araddr changed while waiting");

    single_beat: assert property (@(posedge clk) disable iff (rst)
        beat |-> (r.rlast && r.rid == axi_id))
        else $error("axi_rd_port: beat without rlast or with wrong id");

endmodule

`default_nettype wire

//--- ptw_top.sv
`default_nettype none

module ptw_top #(
    parameter logic [7:0] axi_id = 8'h00
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  mmu_pkg::xlat_req_t xreq,
    output logic               ack,
    output mmu_pkg::xlat_rsp_t rsp,
    output mmu_pkg::axi_ar_t   ar,
    input  logic               arready,
    input  mmu_pkg::axi_r_t    r,
    output logic               rready
);
    import mmu_pkg::*;

    logic            rd_req;
    logic [xlen-1:0] rd_addr;
    logic            rd_ack;
    logic [xlen-1:0] rd_data;

    ptw_walker u_walker (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .xreq    (xreq),
        .ack     (ack),
        .rsp     (rsp),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_ack  (rd_ack),
        .rd_data (rd_data)
    );

    axi_rd_port #(.axi_id(axi_id)) u_port (
        .clk     (clk),
        .rst     (rst),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_ack  (rd_ack),
        .rd_data (rd_data),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

endmodule

`default_nettype wire

//--- tb_ptw.sv
`default_nettype none

module tb_ptw;
    import mmu_pkg::*;

    localparam logic [7:0] axi_id     = 8'h5c;
    localparam int         num_req    = 200;
    localparam int         max_cycles = num_req * 80 + 16; // walks plus reset

    logic      clk = 1'b0;
    logic      rst;
    logic      req;
    xlat_req_t xreq;
    logic      ack;
    xlat_rsp_t rsp;
    axi_ar_t   ar;
    logic      arready;
    axi_r_t    r;
    logic      rready;

    integer          seed = 32'hbd21_b7df;
    int              value_errs = 0;
    int              proto_errs = 0;
    int              cycles = 0;
    logic [63:0]     mem [logic [63:0]]; // sparse page table memory
    logic [63:0]     exp_addr [$];       // entry addresses the model reads
    logic [63:0]     ar_log [$];         // araddr of each AR handshake
    logic            ack_q;
    logic            req_q;              // req in the cycle the walker raised ack
    xlat_rsp_t       rsp_q;

    always #4 clk = ~clk;

    ptw_top #(.axi_id(axi_id)) uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .xreq    (xreq),
        .ack     (ack),
        .rsp     (rsp),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    // random chain of tables for one request, faults injected now and then
    task automatic build_request(output logic [63:0] va, output logic [63:0] satp);
        int          pick;
        int          top;
        int          leaf;
        int          bad;
        int          k;
        logic [43:0] tbl [5];
        logic [63:0] e;
        logic [2:0]  rwx; // x, w, r
        mem.delete();
        va   = {$random(seed), $random(seed)};
        pick = $unsigned($random(seed)) % 16;
        top  = 2 + $unsigned($random(seed)) % 3;
        for (int l = 0; l < 5; l++) begin
            e      = {$random(seed), $random(seed)};
            tbl[l] = {e[43:3], 3'(l)}; // distinct table per level
        end
        satp = {4'(6 + top), e[59:44], tbl[top]};
        if (pick < 2)
            satp[63:60] = 4'($unsigned($random(seed)) % 8); // unsupported mode
        leaf = $unsigned($random(seed)) % (top + 1);
        if (pick == 3)
            leaf = 1 + $unsigned($random(seed)) % top; // superpage only
        if (pick == 4)
            leaf = 0;
        bad = leaf + $unsigned($random(seed)) % (top - leaf + 1);
        for (int l = top; l >= leaf; l--) begin
            if (l > leaf) begin
                e = {10'h000, tbl[l-1], 2'b00, 4'($random(seed)), 4'b0001};
            end else begin
                e   = {$random(seed), $random(seed)};
                rwx = 3'($random(seed));
                if (!rwx[0] && !rwx[2])
                    rwx[0] = 1'b1;
                e = {10'h000, e[53:10], 2'b00, e[7:4], rwx, 1'b1};
                for (int i = 0; i < l; i++)
                    e[10 + 9*i +: 9] = 9'd0;
                if (pick == 3) begin
                    k = $unsigned($random(seed)) % l;
                    e[10 + 9*k +: 9] = 9'(1 + $unsigned($random(seed)) % 511);
                end
                if (pick == 4)
                    e[3:1] = 3'b000; // pointer at level zero
            end
            if (pick == 2 && l == bad)
                e[0] = 1'b0;
            mem[{8'h00, tbl[l], va[12 + 9*l +: 9], 3'b000}] = e;
        end
    endtask

    // reference walk over the memory model
    task automatic model_walk(input logic [63:0] va, input logic [63:0] satp,
                              output logic [63:0] padd, output logic [7:0] perm);
        int          top;
        logic [43:0] ppn;
        logic [63:0] a;
        logic [63:0] e;
        padd = '0;
        perm = '0;
        exp_addr.delete();
        case (satp[63:60])
            4'd8:    top = 2;
            4'd9:    top = 3;
            4'd10:   top = 4;
            default: return; // fault without any read
        endcase
        ppn = satp[43:0];
        for (int l = top; l >= 0; l--) begin
            a = {8'h00, ppn, va[12 + 9*l +: 9], 3'b000};
            exp_addr.push_back(a);
            e = mem.exists(a) ? mem[a] : 64'd0;
            if (!e[0])
                return;
            if (e[1] || e[3]) begin
                ppn = e[53:10];
                for (int i = 0; i < l; i++) begin
                    if (ppn[9*i +: 9] != 9'd0)
                        return; // misaligned superpage
                    ppn[9*i +: 9] = va[12 + 9*i +: 9];
                end
                padd = {8'h00, ppn, 12'h000};
                perm = e[7:0];
                return;
            end
            if (l == 0)
                return;
            ppn = e[53:10];
        end
    endtask

    task automatic check_idle_outputs();
        assert (ack === 1'b0 && ar.arvalid === 1'b0 && rready === 1'b0)
            else begin
                proto_errs++;
                $display("error %0t: ack, arvalid or rready high around reset", $time);
            end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // axi slave with random arready and rvalid delays
    initial begin : axi_slave
        logic [63:0] a;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && ar.arvalid) begin
                a = ar.araddr;
                repeat ($unsigned($random(seed)) % 5) begin
                    @(posedge clk);
                    #1;
                    assert (ar.arvalid && ar.araddr == a) else begin
                        proto_errs++;
                        $display("error %0t: araddr moved while arvalid waited", $time);
                    end
                end
                assert (ar.arlen == 8'd0 && ar.arsize == 3'b011 && ar.arburst == 2'b01
                        && ar.arid == axi_id) else begin
                    proto_errs++;
                    $display("error %0t: bad burst fields or id on AR", $time);
                end
                arready = 1'b1;
                wait_cycles(1);
                arready = 1'b0;
                ar_log.push_back(a);
                wait_cycles($unsigned($random(seed)) % 5);
                r.rid    = axi_id;
                r.rdata  = mem.exists(a) ? mem[a] : 64'd0;
                r.rlast  = 1'b1;
                r.rvalid = 1'b1;
                wait_cycles(1); // beat, rready is already up
                r.rvalid = 1'b0;
            end
        end
    end

    // four-phase order on the requester side
    always @(posedge clk) begin
        if (!rst) begin
            if (ack && !ack_q)
                assert (req_q) else begin
                    proto_errs++;
                    $display("error %0t: ack rose while req was low", $time);
                end
            if (ack && ack_q)
                assert (rsp === rsp_q) else begin
                    proto_errs++;
                    $display("error %0t: rsp changed while ack was high", $time);
                end
        end
        ack_q <= ack;
        req_q <= req;
        rsp_q <= rsp;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: the walker did not finish all requests in %0d cycles", max_cycles);
            $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : requester
        logic [63:0] va;
        logic [63:0] satp;
        logic [63:0] exp_padd;
        logic [7:0]  exp_perm;
        rst     = 1'b1;
        req     = 1'b0;
        xreq    = '0;
        arready = 1'b0;
        r       = '0;
        repeat (16) begin
            wait_cycles(1);
            check_idle_outputs();
        end
        rst = 1'b0;
        wait_cycles(1);
        check_idle_outputs(); // first cycle out of reset
        for (int n = 0; n < num_req; n++) begin
            build_request(va, satp);
            model_walk(va, satp, exp_padd, exp_perm);
            ar_log.delete();
            wait_cycles($unsigned($random(seed)) % 4);
            req        = 1'b1;
            xreq.vaddr = va;
            xreq.satp  = satp;
            do wait_cycles(1); while (!ack);
            assert (rsp.padd == exp_padd && rsp.perm == exp_perm) else begin
                value_errs++;
                $display("error %0t: request %0d gave padd %h perm %h, expected %h %h",
                         $time, n, rsp.padd, rsp.perm, exp_padd, exp_perm);
            end
            wait_cycles($unsigned($random(seed)) % 4); // requester holds req a while
            req = 1'b0;
            do wait_cycles(1); while (ack);
            assert (ar_log.size() == exp_addr.size()) else begin
                value_errs++;
                $display("error %0t: request %0d made %0d reads, expected %0d",
                         $time, n, ar_log.size(), exp_addr.size());
            end
            for (int i = 0; i < ar_log.size() && i < exp_addr.size(); i++)
                assert (ar_log[i] == exp_addr[i]) else begin
                    value_errs++;
                    $display("error %0t: request %0d read %0d at %h, expected %h",
                             $time, n, i, ar_log[i], exp_addr[i]);
                end
        end
        $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
mmu_pkg.sv
pte_check.sv
ptw_walker.sv
axi_rd_port.sv
ptw_top.sv
tb_ptw.sv

//--- Bender.yml
package:
  name: ptw

sources:
  # package first, then leaf modules, then the top level
  - mmu_pkg.sv
  - pte_check.sv
  - ptw_walker.sv
  - axi_rd_port.sv
  - ptw_top.sv

  - target: test
    files:
      - tb_ptw.sv

__________________________________________________________________________
